// ==== controlPkg.sv ====
`default_nettype none

package controlPkg;

	localparam int OpcodeWidth = 6;
	localparam int FunctWidth = 6;
	localparam int ClassWidth = 4;
	localparam int StateWidth = 5;

	localparam logic CauseIllegal = 1'b0;
	localparam logic CauseOverflow = 1'b1;

	typedef enum logic [OpcodeWidth-1:0]
	{
		opSpecial = 6'h00,
		opJ = 6'h02,
		opBeq = 6'h04,
		opBne = 6'h05,
		opAddi = 6'h08,
		opAddiu = 6'h09,
		opSlti = 6'h0a,
		opAndi = 6'h0c,
		opXori = 6'h0e,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcodeT;

	typedef enum logic [FunctWidth-1:0]
	{
		functSll = 6'h00,
		functSrl = 6'h02,
		functSra = 6'h03,
		functSllv = 6'h04,
		functSrav = 6'h07,
		functJr = 6'h08,
		functBreak = 6'h0d,
		functAdd = 6'h20,
		functAddu = 6'h21,
		functSub = 6'h22,
		functSubu = 6'h23,
		functAnd = 6'h24,
		functXor = 6'h26,
		functSlt = 6'h2a
	} functT;

	// Memory class split by direction so the sequencer can steer after address setup
	typedef enum logic [ClassWidth-1:0]
	{
		classRType, classIType, classShiftImm, classShiftVar,
		classMemLoad, classMemStore, classBranchEq, classBranchNe,
		classJump, classJumpReg, classHalt, classIllegal
	} instrClassT;

	typedef enum logic [StateWidth-1:0]
	{
		stateMemRead, stateFetchWait, stateIrWrite, stateDecode,
		stateClassR, stateClassI, stateClassShift, stateClassShiftVar,
		stateWriteRd, stateWriteShift, stateWriteSlt,
		stateMemAddr, stateLoadRead, stateLoadWait1, stateLoadWait2,
		stateLoadWriteBack, stateStore,
		stateBranchEq, stateBranchNe, stateJump, stateJumpReg, stateHalt,
		stateIllegalInstr, stateOverflowTrap, stateExceptionWait, stateExceptionEntry
	} stateT;

	typedef enum logic [1:0]
	{
		pcSrcAluResult = 2'd0,
		pcSrcBranchTarget = 2'd1,
		pcSrcJumpTarget = 2'd2
	} pcSourceT;

	typedef enum logic [1:0]
	{
		aluASrcPc = 2'd0,
		aluASrcRegA = 2'd1,
		aluASrcExceptionVector = 2'd2
	} aluSrcAT;

	typedef enum logic [1:0]
	{
		aluBSrcRegB = 2'd0,
		aluBSrcFour = 2'd1,
		aluBSrcImmediate = 2'd2,
		aluBSrcShiftedImmediate = 2'd3
	} aluSrcBT;

	typedef enum logic [1:0]
	{
		aluOpAdd = 2'd0,
		aluOpSubtract = 2'd1,
		aluOpByFunct = 2'd2,
		aluOpPassA = 2'd3
	} aluOpT;

	typedef enum logic
	{
		regDstRt = 1'b0,
		regDstRd = 1'b1
	} regDstT;

	typedef enum logic [1:0]
	{
		memToRegAluOut = 2'd0,
		memToRegMdr = 2'd1,
		memToRegShifter = 2'd2,
		memToRegSlt = 2'd3
	} memToRegT;

	typedef enum logic [1:0]
	{
		addrSrcPc = 2'd0,
		addrSrcAluOut = 2'd1,
		addrSrcExceptionAddress = 2'd2
	} addrSourceT;

endpackage

`default_nettype wire

// ==== ctrlBundleIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlBundleIf import controlPkg::*; ();

	logic memWrite;
	logic pcWrite;
	logic pcWriteEq; // Taken only if ALU zero
	logic pcWriteNe; // Taken only if ALU nonzero
	logic regWrite;
	logic irWrite;
	logic mdrWrite;
	logic aluOutWrite;
	logic causeWrite;
	logic epcWrite;
	logic exceptionCause;
	logic shiftByRegister; // Shift amount from rs instead of shamt
	pcSourceT pcSource;
	aluSrcAT aluSrcA;
	aluSrcBT aluSrcB;
	aluOpT aluOp;
	regDstT regDst;
	memToRegT memToReg;
	addrSourceT addrSource;

	modport encoder (output memWrite, pcWrite, pcWriteEq, pcWriteNe, regWrite, irWrite,
		mdrWrite, aluOutWrite, causeWrite, epcWrite, exceptionCause, shiftByRegister,
		pcSource, aluSrcA, aluSrcB, aluOp, regDst, memToReg, addrSource);

	modport sink (input memWrite, pcWrite, pcWriteEq, pcWriteNe, regWrite, irWrite,
		mdrWrite, aluOutWrite, causeWrite, epcWrite, exceptionCause, shiftByRegister,
		pcSource, aluSrcA, aluSrcB, aluOp, regDst, memToReg, addrSource);

endinterface

`default_nettype wire

// ==== instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import controlPkg::*;
(
	input opcodeT opcode,
	input functT funct,
	output instrClassT instrClass,
	output logic isSlt,
	output logic trapsOverflow
);

	always_comb
	begin
		instrClass = classIllegal;
		isSlt = 1'b0;
		trapsOverflow = 1'b1;
		case (opcode)
			opSpecial:
			begin
				case (funct)
					functAdd, functSub, functAnd, functXor: instrClass = classRType;
					functAddu, functSubu:
					begin
						instrClass = classRType;
						trapsOverflow = 1'b0; // Unsigned forms never trap
					end
					functSlt:
					begin
						instrClass = classRType;
						isSlt = 1'b1;
					end
					functSll, functSrl, functSra: instrClass = classShiftImm;
					functSllv, functSrav: instrClass = classShiftVar;
					functJr: instrClass = classJumpReg;
					functBreak: instrClass = classHalt;
					default: instrClass = classIllegal;
				endcase
			end
			opAddi, opAndi, opXori: instrClass = classIType;
			opAddiu:
			begin
				instrClass = classIType;
				trapsOverflow = 1'b0;
			end
			opSlti:
			begin
				instrClass = classIType;
				isSlt = 1'b1;
			end
			opLw: instrClass = classMemLoad;
			opSw: instrClass = classMemStore;
			opBeq: instrClass = classBranchEq;
			opBne: instrClass = classBranchNe;
			opJ: instrClass = classJump;
			default: instrClass = classIllegal;
		endcase
	end

endmodule

`default_nettype wire

// ==== sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sequencer import controlPkg::*;
(
	input wire clock,
	input wire reset,
	input instrClassT instrClass,
	input wire isSlt,
	input wire trapsOverflow,
	input wire overflow,
	output stateT state
);

	stateT nextState;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= stateMemRead;
		end
		else
		begin
			state <= nextState;
		end
	end

	always_comb
	begin
		nextState = state;
		case (state)
			stateMemRead: nextState = stateFetchWait;
			stateFetchWait: nextState = stateIrWrite;
			stateIrWrite: nextState = stateDecode;
			stateDecode:
			begin
				case (instrClass)
					classRType: nextState = stateClassR;
					classIType: nextState = stateClassI;
					classShiftImm: nextState = stateClassShift;
					classShiftVar: nextState = stateClassShiftVar;
					classMemLoad, classMemStore: nextState = stateMemAddr;
					classBranchEq: nextState = stateBranchEq;
					classBranchNe: nextState = stateBranchNe;
					classJump: nextState = stateJump;
					classJumpReg: nextState = stateJumpReg;
					classHalt: nextState = stateHalt;
					default: nextState = stateIllegalInstr;
				endcase
			end
			stateClassR, stateClassI: nextState = isSlt ? stateWriteSlt : stateWriteRd;
			stateClassShift, stateClassShiftVar: nextState = stateWriteShift;
			stateWriteRd:
			begin
				if (overflow && trapsOverflow)
				begin
					nextState = stateOverflowTrap;
				end
				else
				begin
					nextState = stateMemRead;
				end
			end
			stateWriteShift, stateWriteSlt: nextState = stateMemRead;
			stateMemAddr: nextState = stateLoadRead;
			// Address setup cycle shared by lw and sw
			stateLoadRead:
			begin
				if (instrClass == classMemStore)
				begin
					nextState = stateStore;
				end
				else
				begin
					nextState = stateLoadWait1;
				end
			end
			stateLoadWait1: nextState = stateLoadWait2;
			stateLoadWait2: nextState = stateLoadWriteBack;
			stateLoadWriteBack, stateStore: nextState = stateMemRead;
			stateBranchEq, stateBranchNe: nextState = stateMemRead;
			stateJump, stateJumpReg: nextState = stateMemRead;
			stateHalt: nextState = stateHalt; // Only reset leaves
			stateIllegalInstr, stateOverflowTrap: nextState = stateExceptionWait;
			stateExceptionWait: nextState = stateExceptionEntry; // Vector read latency
			stateExceptionEntry: nextState = stateMemRead;
			default: nextState = stateMemRead;
		endcase
	end

endmodule

`default_nettype wire

// ==== controlEncoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlEncoder import controlPkg::*;
(
	input stateT state,
	ctrlBundleIf.encoder ctrl
);

	always_comb
	begin
		ctrl.memWrite = 1'b0;
		ctrl.pcWrite = 1'b0;
		ctrl.pcWriteEq = 1'b0;
		ctrl.pcWriteNe = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.irWrite = 1'b0;
		ctrl.mdrWrite = 1'b0;
		ctrl.aluOutWrite = 1'b0;
		ctrl.causeWrite = 1'b0;
		ctrl.epcWrite = 1'b0;
		ctrl.exceptionCause = CauseIllegal;
		ctrl.shiftByRegister = 1'b0;
		ctrl.pcSource = pcSrcAluResult;
		ctrl.aluSrcA = aluASrcPc;
		ctrl.aluSrcB = aluBSrcRegB;
		ctrl.aluOp = aluOpAdd;
		ctrl.regDst = regDstRt;
		ctrl.memToReg = memToRegAluOut;
		ctrl.addrSource = addrSrcPc;
		case (state)
			stateMemRead:
			begin
				ctrl.pcWrite = 1'b1; // PC + 4 while memory is read
				ctrl.aluSrcB = aluBSrcFour;
			end
			stateIrWrite:
			begin
				ctrl.irWrite = 1'b1;
				ctrl.aluSrcB = aluBSrcShiftedImmediate; // Branch target ahead of decode
				ctrl.aluOutWrite = 1'b1;
			end
			stateClassR:
			begin
				ctrl.aluSrcA = aluASrcRegA;
				ctrl.aluOp = aluOpByFunct;
				ctrl.aluOutWrite = 1'b1;
			end
			stateClassI:
			begin
				ctrl.aluSrcA = aluASrcRegA;
				ctrl.aluSrcB = aluBSrcImmediate;
				ctrl.aluOp = aluOpByFunct;
				ctrl.aluOutWrite = 1'b1;
			end
			stateClassShift: ctrl.aluOp = aluOpByFunct;
			stateClassShiftVar:
			begin
				ctrl.shiftByRegister = 1'b1;
				ctrl.aluOp = aluOpByFunct;
			end
			stateWriteRd:
			begin
				ctrl.aluOp = aluOpByFunct; // Keeps overflow valid
				ctrl.regDst = regDstRd;
				ctrl.regWrite = 1'b1;
			end
			stateWriteShift:
			begin
				ctrl.regDst = regDstRd;
				ctrl.memToReg = memToRegShifter;
				ctrl.regWrite = 1'b1;
			end
			stateWriteSlt:
			begin
				ctrl.aluSrcA = aluASrcRegA;
				ctrl.aluOp = aluOpByFunct;
				ctrl.regDst = regDstRd;
				ctrl.memToReg = memToRegSlt;
				ctrl.regWrite = 1'b1;
			end
			stateMemAddr:
			begin
				ctrl.aluSrcA = aluASrcRegA;
				ctrl.aluSrcB = aluBSrcImmediate;
				ctrl.addrSource = addrSrcAluOut;
				ctrl.aluOutWrite = 1'b1;
			end
			stateLoadRead, stateLoadWait1: ctrl.addrSource = addrSrcAluOut;
			stateLoadWait2:
			begin
				ctrl.addrSource = addrSrcAluOut;
				ctrl.mdrWrite = 1'b1; // Data ready after two waits
			end
			stateLoadWriteBack:
			begin
				ctrl.memToReg = memToRegMdr;
				ctrl.regWrite = 1'b1;
			end
			stateStore:
			begin
				ctrl.addrSource = addrSrcAluOut;
				ctrl.memWrite = 1'b1;
			end
			stateBranchEq:
			begin
				ctrl.aluSrcA = aluASrcRegA;
				ctrl.aluOp = aluOpSubtract;
				ctrl.pcSource = pcSrcBranchTarget;
				ctrl.pcWriteEq = 1'b1;
			end
			stateBranchNe:
			begin
				ctrl.aluSrcA = aluASrcRegA;
				ctrl.aluOp = aluOpSubtract;
				ctrl.pcSource = pcSrcBranchTarget;
				ctrl.pcWriteNe = 1'b1;
			end
			stateJump:
			begin
				ctrl.pcSource = pcSrcJumpTarget;
				ctrl.pcWrite = 1'b1;
			end
			stateJumpReg:
			begin
				ctrl.aluSrcA = aluASrcRegA; // rs through the ALU
				ctrl.aluOp = aluOpPassA;
				ctrl.pcWrite = 1'b1;
			end
			stateIllegalInstr, stateOverflowTrap:
			begin
				ctrl.exceptionCause = (state == stateOverflowTrap) ? CauseOverflow : CauseIllegal;
				ctrl.causeWrite = 1'b1;
				ctrl.epcWrite = 1'b1;
				ctrl.aluOp = aluOpPassA;
				ctrl.addrSource = addrSrcExceptionAddress;
			end
			stateExceptionWait: ctrl.addrSource = addrSrcExceptionAddress;
			stateExceptionEntry:
			begin
				ctrl.aluSrcA = aluASrcExceptionVector;
				ctrl.aluOp = aluOpPassA;
				ctrl.addrSource = addrSrcExceptionAddress;
				ctrl.pcWrite = 1'b1; // Handler address into PC
			end
			default: ctrl.pcWrite = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit import controlPkg::*;
(
	input wire clock,
	input wire reset,
	input opcodeT opcode,
	input functT funct,
	input wire overflow,
	output logic memWrite,
	output logic pcWrite,
	output logic pcWriteEq,
	output logic pcWriteNe,
	output logic regWrite,
	output logic irWrite,
	output logic mdrWrite,
	output logic aluOutWrite,
	output logic causeWrite,
	output logic epcWrite,
	output logic exceptionCause,
	output logic shiftByRegister,
	output pcSourceT pcSource,
	output aluSrcAT aluSrcA,
	output aluSrcBT aluSrcB,
	output aluOpT aluOp,
	output regDstT regDst,
	output memToRegT memToReg,
	output addrSourceT addrSource,
	output stateT state
);

	instrClassT instrClass;
	logic isSlt;
	logic trapsOverflow;

	ctrlBundleIf bundle ();

	instrDecoder i_instrDecoder (.opcode(opcode), .funct(funct), .instrClass(instrClass),
		.isSlt(isSlt), .trapsOverflow(trapsOverflow));

	sequencer i_sequencer (.clock(clock), .reset(reset), .instrClass(instrClass),
		.isSlt(isSlt), .trapsOverflow(trapsOverflow), .overflow(overflow), .state(state));

	controlEncoder i_controlEncoder (.state(state), .ctrl(bundle.encoder));

	// Sink side of the bundle out to plain ports
	assign memWrite = bundle.memWrite;
	assign pcWrite = bundle.pcWrite;
	assign pcWriteEq = bundle.pcWriteEq;
	assign pcWriteNe = bundle.pcWriteNe;
	assign regWrite = bundle.regWrite;
	assign irWrite = bundle.irWrite;
	assign mdrWrite = bundle.mdrWrite;
	assign aluOutWrite = bundle.aluOutWrite;
	assign causeWrite = bundle.causeWrite;
	assign epcWrite = bundle.epcWrite;
	assign exceptionCause = bundle.exceptionCause;
	assign shiftByRegister = bundle.shiftByRegister;
	assign pcSource = bundle.pcSource;
	assign aluSrcA = bundle.aluSrcA;
	assign aluSrcB = bundle.aluSrcB;
	assign aluOp = bundle.aluOp;
	assign regDst = bundle.regDst;
	assign memToReg = bundle.memToReg;
	assign addrSource = bundle.addrSource;

endmodule

`default_nettype wire

// ==== tbControlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbControlUnit import controlPkg::*;
();

	typedef struct packed
	{
		logic memWrite, pcWrite, pcWriteEq, pcWriteNe, regWrite, irWrite;
		logic mdrWrite, aluOutWrite, causeWrite, epcWrite, exceptionCause, shiftByRegister;
		pcSourceT pcSource;
		aluSrcAT aluSrcA;
		aluSrcBT aluSrcB;
		aluOpT aluOp;
		regDstT regDst;
		memToRegT memToReg;
		addrSourceT addrSource;
	} bundleT;

	logic clock;
	logic reset;
	opcodeT opcode;
	functT funct;
	logic overflow;
	logic memWrite, pcWrite, pcWriteEq, pcWriteNe, regWrite, irWrite;
	logic mdrWrite, aluOutWrite, causeWrite, epcWrite, exceptionCause, shiftByRegister;
	pcSourceT pcSource;
	aluSrcAT aluSrcA;
	aluSrcBT aluSrcB;
	aluOpT aluOp;
	regDstT regDst;
	memToRegT memToReg;
	addrSourceT addrSource;
	stateT state;

	stateT expState = stateMemRead;
	bundleT expBundle;
	opcodeT testOp[$];
	functT testFn[$];
	logic testOvf[$];
	logic testsReady = 1'b0;
	logic [31:0] lfsrState = 32'h845a_6689;
	int errorCount = 0;
	int checkCount = 0;

	controlUnit i_dut (.clock(clock), .reset(reset), .opcode(opcode), .funct(funct),
		.overflow(overflow), .memWrite(memWrite), .pcWrite(pcWrite), .pcWriteEq(pcWriteEq),
		.pcWriteNe(pcWriteNe), .regWrite(regWrite), .irWrite(irWrite), .mdrWrite(mdrWrite),
		.aluOutWrite(aluOutWrite), .causeWrite(causeWrite), .epcWrite(epcWrite),
		.exceptionCause(exceptionCause), .shiftByRegister(shiftByRegister),
		.pcSource(pcSource), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp),
		.regDst(regDst), .memToReg(memToReg), .addrSource(addrSource), .state(state));

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic int unsigned drawBits(input int count);
		int unsigned value;
		value = 0;
		repeat (count)
		begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
		end
		return value;
	endfunction

	function automatic logic isSltInstr(input opcodeT op, input functT fn);
		return (op == opSlti) || (op == opSpecial && fn == functSlt);
	endfunction

	// Unsigned adds and subtracts ignore overflow
	function automatic logic trapsInstr(input opcodeT op, input functT fn);
		return !(op == opAddiu || (op == opSpecial && (fn == functAddu || fn == functSubu)));
	endfunction

	function automatic stateT decodeTarget(input opcodeT op, input functT fn);
		stateT next;
		next = stateIllegalInstr;
		case (op)
			opSpecial:
				case (fn)
					functAdd, functAddu, functSub, functSubu, functAnd, functXor, functSlt:
						next = stateClassR;
					functSll, functSrl, functSra: next = stateClassShift;
					functSllv, functSrav: next = stateClassShiftVar;
					functJr: next = stateJumpReg;
					functBreak: next = stateHalt;
					default: next = stateIllegalInstr;
				endcase
			opAddi, opAddiu, opSlti, opAndi, opXori: next = stateClassI;
			opLw, opSw: next = stateMemAddr;
			opBeq: next = stateBranchEq;
			opBne: next = stateBranchNe;
			opJ: next = stateJump;
			default: next = stateIllegalInstr;
		endcase
		return next;
	endfunction

	function automatic stateT refNextState(input stateT s, input opcodeT op, input functT fn,
		input logic ovf);
		stateT next;
		case (s)
			stateMemRead: next = stateFetchWait;
			stateFetchWait: next = stateIrWrite;
			stateIrWrite: next = stateDecode;
			stateDecode: next = decodeTarget(op, fn);
			stateClassR, stateClassI: next = isSltInstr(op, fn) ? stateWriteSlt : stateWriteRd;
			stateClassShift, stateClassShiftVar: next = stateWriteShift;
			stateWriteRd: next = (ovf && trapsInstr(op, fn)) ? stateOverflowTrap : stateMemRead;
			stateMemAddr: next = stateLoadRead;
			stateLoadRead: next = (op == opSw) ? stateStore : stateLoadWait1;
			stateLoadWait1: next = stateLoadWait2;
			stateLoadWait2: next = stateLoadWriteBack;
			stateHalt: next = stateHalt;
			stateIllegalInstr, stateOverflowTrap: next = stateExceptionWait;
			stateExceptionWait: next = stateExceptionEntry;
			default: next = stateMemRead;
		endcase
		return next;
	endfunction

	function automatic bundleT refBundle(input stateT s);
		bundleT b;
		b.memWrite = (s == stateStore);
		b.pcWrite = s inside {stateMemRead, stateJump, stateJumpReg, stateExceptionEntry};
		b.pcWriteEq = (s == stateBranchEq);
		b.pcWriteNe = (s == stateBranchNe);
		b.regWrite = s inside {stateWriteRd, stateWriteShift, stateWriteSlt, stateLoadWriteBack};
		b.irWrite = (s == stateIrWrite);
		b.mdrWrite = (s == stateLoadWait2);
		b.aluOutWrite = s inside {stateIrWrite, stateClassR, stateClassI, stateMemAddr};
		b.causeWrite = s inside {stateIllegalInstr, stateOverflowTrap};
		b.epcWrite = b.causeWrite;
		b.exceptionCause = (s == stateOverflowTrap);
		b.shiftByRegister = (s == stateClassShiftVar);
		b.pcSource = (s inside {stateBranchEq, stateBranchNe}) ? pcSrcBranchTarget
			: (s == stateJump) ? pcSrcJumpTarget : pcSrcAluResult;
		b.aluSrcA = (s == stateExceptionEntry) ? aluASrcExceptionVector
			: (s inside {stateClassR, stateClassI, stateWriteSlt, stateMemAddr, stateBranchEq,
			stateBranchNe, stateJumpReg}) ? aluASrcRegA : aluASrcPc;
		b.aluSrcB = (s == stateMemRead) ? aluBSrcFour
			: (s == stateIrWrite) ? aluBSrcShiftedImmediate
			: (s inside {stateClassI, stateMemAddr}) ? aluBSrcImmediate : aluBSrcRegB;
		b.aluOp = (s inside {stateClassR, stateClassI, stateClassShift, stateClassShiftVar,
			stateWriteRd, stateWriteSlt}) ? aluOpByFunct
			: (s inside {stateBranchEq, stateBranchNe}) ? aluOpSubtract
			: (s inside {stateJumpReg, stateIllegalInstr, stateOverflowTrap,
			stateExceptionEntry}) ? aluOpPassA : aluOpAdd;
		b.regDst = (s inside {stateWriteRd, stateWriteShift, stateWriteSlt}) ? regDstRd : regDstRt;
		b.memToReg = (s == stateWriteShift) ? memToRegShifter
			: (s == stateWriteSlt) ? memToRegSlt
			: (s == stateLoadWriteBack) ? memToRegMdr : memToRegAluOut;
		b.addrSource = (s inside {stateMemAddr, stateLoadRead, stateLoadWait1, stateLoadWait2,
			stateStore}) ? addrSrcAluOut
			: (s inside {stateIllegalInstr, stateOverflowTrap, stateExceptionWait,
			stateExceptionEntry}) ? addrSrcExceptionAddress : addrSrcPc;
		return b;
	endfunction

	// Cycles from memRead back to memRead
	function automatic int expectedCycles(input opcodeT op, input functT fn, input logic ovf);
		case (decodeTarget(op, fn))
			stateClassR, stateClassI:
				return (ovf && trapsInstr(op, fn) && !isSltInstr(op, fn)) ? 9 : 6;
			stateClassShift, stateClassShiftVar: return 6;
			stateMemAddr: return (op == opLw) ? 9 : 7;
			stateIllegalInstr: return 7;
			default: return 5;
		endcase
	endfunction

	function automatic string instrName(input opcodeT op, input functT fn);
		string name;
		name = (op == opSpecial) ? fn.name() : op.name();
		return (name == "") ? "unknown" : name;
	endfunction

	task automatic reportMismatch(input string name, input int unsigned actual,
		input int unsigned expected);
		$display("mismatch %s at %0t ns: got %h, expected %h", name, $time, actual, expected);
		errorCount++;
	endtask

	task automatic compareState(input stateT actual, input stateT expected);
		if (actual !== expected)
			reportMismatch("state", actual, expected);
	endtask

	task automatic compareEnable(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			reportMismatch(name, actual, expected);
	endtask

	task automatic compareSelectPc(input pcSourceT actual, input pcSourceT expected);
		if (actual !== expected)
			reportMismatch("pcSource", actual, expected);
	endtask

	task automatic compareSelectAluA(input aluSrcAT actual, input aluSrcAT expected);
		if (actual !== expected)
			reportMismatch("aluSrcA", actual, expected);
	endtask

	task automatic compareSelectAluB(input aluSrcBT actual, input aluSrcBT expected);
		if (actual !== expected)
			reportMismatch("aluSrcB", actual, expected);
	endtask

	task automatic compareSelectAluOp(input aluOpT actual, input aluOpT expected);
		if (actual !== expected)
			reportMismatch("aluOp", actual, expected);
	endtask

	task automatic compareSelectRegDst(input regDstT actual, input regDstT expected);
		if (actual !== expected)
			reportMismatch("regDst", actual, expected);
	endtask

	task automatic compareSelectMemToReg(input memToRegT actual, input memToRegT expected);
		if (actual !== expected)
			reportMismatch("memToReg", actual, expected);
	endtask

	task automatic compareSelectAddr(input addrSourceT actual, input addrSourceT expected);
		if (actual !== expected)
			reportMismatch("addrSource", actual, expected);
	endtask

	task automatic addTest(input opcodeT op, input functT fn, input logic ovf);
		testOp.push_back(op);
		testFn.push_back(fn);
		testOvf.push_back(ovf);
	endtask

	// Mid cycle, away from the clock edge and the input updates
	always @(negedge clock)
	begin
		expBundle = refBundle(expState);
		compareState(state, expState);
		compareEnable("memWrite", memWrite, expBundle.memWrite);
		compareEnable("pcWrite", pcWrite, expBundle.pcWrite);
		compareEnable("pcWriteEq", pcWriteEq, expBundle.pcWriteEq);
		compareEnable("pcWriteNe", pcWriteNe, expBundle.pcWriteNe);
		compareEnable("regWrite", regWrite, expBundle.regWrite);
		compareEnable("irWrite", irWrite, expBundle.irWrite);
		compareEnable("mdrWrite", mdrWrite, expBundle.mdrWrite);
		compareEnable("aluOutWrite", aluOutWrite, expBundle.aluOutWrite);
		compareEnable("causeWrite", causeWrite, expBundle.causeWrite);
		compareEnable("epcWrite", epcWrite, expBundle.epcWrite);
		compareEnable("exceptionCause", exceptionCause, expBundle.exceptionCause);
		compareEnable("shiftByRegister", shiftByRegister, expBundle.shiftByRegister);
		compareSelectPc(pcSource, expBundle.pcSource);
		compareSelectAluA(aluSrcA, expBundle.aluSrcA);
		compareSelectAluB(aluSrcB, expBundle.aluSrcB);
		compareSelectAluOp(aluOp, expBundle.aluOp);
		compareSelectRegDst(regDst, expBundle.regDst);
		compareSelectMemToReg(memToReg, expBundle.memToReg);
		compareSelectAddr(addrSource, expBundle.addrSource);
		checkCount += 20;
		if (!reset)
			expState = refNextState(expState, opcode, funct, overflow);
	end

	initial
	begin
		int limitCycles;
		wait (testsReady);
		limitCycles = testOp.size() * 9 + 3 + 24 + 50; // Reset, break and margin
		#(limitCycles * 4);
		$display("timeout: the tests did not finish within %0d cycles", limitCycles);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		int unsigned pick;
		int unsigned ovfBit;
		int directedCount;
		int cycles;
		int writes;
		int expectedWrites;
		int errorsBefore;
		logic haltLost;
		reset = 1'b1;
		opcode = opSpecial;
		funct = functSll;
		overflow = 1'b0;
		addTest(opSpecial, functAdd, 1'b0);
		addTest(opSpecial, functSub, 1'b0);
		addTest(opSpecial, functAnd, 1'b0);
		addTest(opSpecial, functXor, 1'b0);
		addTest(opSpecial, functSlt, 1'b0);
		addTest(opSpecial, functAddu, 1'b0);
		addTest(opSpecial, functSubu, 1'b0);
		addTest(opAddi, functSll, 1'b0);
		addTest(opAddiu, functSll, 1'b0);
		addTest(opSlti, functSll, 1'b0);
		addTest(opAndi, functSll, 1'b0);
		addTest(opXori, functSll, 1'b0);
		addTest(opSpecial, functAdd, 1'b1); // Overflow forced high
		addTest(opSpecial, functSub, 1'b1);
		addTest(opAddi, functSll, 1'b1);
		addTest(opSpecial, functAddu, 1'b1);
		addTest(opSpecial, functSubu, 1'b1);
		addTest(opAddiu, functSll, 1'b1);
		addTest(opSpecial, functSll, 1'b0);
		addTest(opSpecial, functSrl, 1'b0);
		addTest(opSpecial, functSra, 1'b0);
		addTest(opSpecial, functSllv, 1'b0);
		addTest(opSpecial, functSrav, 1'b0);
		addTest(opLw, functSll, 1'b0);
		addTest(opSw, functSll, 1'b0);
		addTest(opBeq, functSll, 1'b0);
		addTest(opBne, functSll, 1'b0);
		addTest(opJ, functSll, 1'b0);
		addTest(opSpecial, functJr, 1'b0);
		addTest(opcodeT'(6'h3f), functSll, 1'b0);
		addTest(opSpecial, functT'(6'h3f), 1'b0);
		directedCount = testOp.size();
		repeat (40)
		begin
			pick = drawBits(5);
			ovfBit = drawBits(1);
			pick = pick % directedCount;
			addTest(testOp[pick], testFn[pick], ovfBit[0]);
		end
		testsReady = 1'b1;
		repeat (3) @(posedge clock);
		#1 reset = 1'b0;
		foreach (testOp[i])
		begin
			opcode = testOp[i];
			funct = testFn[i];
			overflow = testOvf[i];
			errorsBefore = errorCount;
			cycles = 0;
			writes = 0;
			do
			begin
				@(posedge clock);
				#1;
				cycles++;
				if (memWrite)
					writes++;
			end
			while (state != stateMemRead);
			if (cycles != expectedCycles(testOp[i], testFn[i], testOvf[i]))
			begin
				$display("test %0d took %0d cycles instead of %0d", i, cycles,
					expectedCycles(testOp[i], testFn[i], testOvf[i]));
				errorCount++;
			end
			expectedWrites = (testOp[i] == opSw) ? 1 : 0;
			if (writes != expectedWrites)
			begin
				$display("test %0d asserted memWrite %0d times instead of %0d", i, writes,
					expectedWrites);
				errorCount++;
			end
			$display("test %0d %s: opcode %h funct %h overflow %0b, %0d cycles, %s", i,
				instrName(testOp[i], testFn[i]), testOp[i], testFn[i], testOvf[i], cycles,
				(errorCount == errorsBefore) ? "ok" : "failed");
		end
		opcode = opSpecial; // break goes last, only reset leaves halt
		funct = functBreak;
		overflow = 1'b0;
		errorsBefore = errorCount;
		haltLost = 1'b0;
		repeat (4) @(posedge clock);
		repeat (20)
		begin
			@(posedge clock);
			#1;
			if (state != stateHalt)
				haltLost = 1'b1;
		end
		if (haltLost)
		begin
			$display("break did not hold the halt state for 20 cycles");
			errorCount++;
		end
		$display("test %0d break: halt held for 20 cycles, %s", testOp.size(),
			(errorCount == errorsBefore) ? "ok" : "failed");
		$display("%0d tests, %0d checks, %0d errors", testOp.size() + 1, checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
controlPkg.sv
ctrlBundleIf.sv
instrDecoder.sv
sequencer.sv
controlEncoder.sv
controlUnit.sv
tbControlUnit.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tbControlUnit -f tb.f
./obj_dir/VtbControlUnit | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0
